/* verilog.f */
+incdir+verif
logic/csr_types_pkg.sv
logic/csr_addr_pkg.sv
logic/csr_trap_ctrl.sv
logic/csr_regfile.sv
logic/csr_read_port.sv
logic/csr_unit.sv
verif/csr_tb.sv

/* verif/csr_tb_tasks.svh */
// Directed tests for the CSR unit, included inside the testbench module.
// Expected values follow the RV32 mstatus layout and the unit's rules.
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: %s expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic write_and_read_back(input string what, input csr_addr_t addr,
                                       input word_t keep);
        word_t data;
        word_t value;
        data = next_random();
        write_csr(addr, data);
        read_csr(addr, value);
        check_word(what, data & keep, value);
    endtask

    task automatic raise_trap(input cause_t cause, input word_t tval, input word_t pc,
                              output word_t target);
        @(posedge clk);
        drive_idle();
        trap_valid <= 1'b1;
        trap_cause <= cause;
        trap_tval  <= tval;
        trap_pc    <= pc;
        @(negedge clk);
        target = next_pc;
    endtask

    task automatic return_from_trap(input privilege_t level, output word_t target);
        @(posedge clk);
        drive_idle();
        trap_return      <= 1'b1;
        trap_return_priv <= level;
        @(negedge clk);
        target = next_pc;
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_after_reset();
        word_t value;
        test_name = "after_reset";
        idle_cycle();
        check_word("privilege", 32'd3, {30'd0, privilege});
        check_word("mstatus", 32'h0, mstatus);
        check_word("next_pc idle", 32'h0, next_pc);
        read_csr(MISA, value);
        check_word("misa", 32'h4000_0100, value);
        read_csr(MVENDORID, value);
        check_word("mvendorid", 32'h0, value);
        read_csr(MARCHID, value);
        check_word("marchid", 32'h0, value);
        read_csr(MIMPID, value);
        check_word("mimpid", 32'h0, value);
        read_csr(MHARTID, value);
        check_word("mhartid", 32'h0, value);
        read_csr(12'h7C0, value);
        check_word("unmapped 0x7c0", 32'h0, value);
    endtask

    task automatic test_write_readback();
        test_name = "write_readback";
        write_and_read_back("mscratch", MSCRATCH, 32'hFFFF_FFFF);
        write_and_read_back("sscratch", SSCRATCH, 32'hFFFF_FFFF);
        write_and_read_back("mtvec", MTVEC, 32'hFFFF_FFFF);
        write_and_read_back("stvec", STVEC, 32'hFFFF_FFFF);
        write_and_read_back("mepc", MEPC, 32'hFFFF_FFFF);
        write_and_read_back("sepc", SEPC, 32'hFFFF_FFFF);
        write_and_read_back("mtval", MTVAL, 32'hFFFF_FFFF);
        write_and_read_back("stval", STVAL, 32'hFFFF_FFFF);
        write_and_read_back("medeleg", MEDELEG, 32'hFFFF_FFFF);
        // Cause registers keep only the 4-bit exception code
        write_and_read_back("mcause", MCAUSE, 32'h0000_000F);
        write_and_read_back("scause", SCAUSE, 32'h0000_000F);
    endtask

    task automatic test_sstatus_mask();
        word_t data;
        word_t value;
        test_name = "sstatus_mask";
        write_csr(MSTATUS, 32'h0);
        write_csr(SSTATUS, 32'hFFFF_FFFF);
        idle_cycle();
        check_word("mstatus after sstatus ones", 32'h800D_E133, mstatus);
        data = next_random();
        write_csr(MSTATUS, data);
        read_csr(SSTATUS, value);
        check_word("sstatus view", data & 32'h800D_E133, value);
        read_csr(MSTATUS, value);
        check_word("mstatus raw", data, value);
    endtask

    task automatic test_trap_entry();
        word_t      mtvec_val;
        word_t      stvec_val;
        word_t      pc;
        word_t      tval;
        word_t      value;
        word_t      target;
        privilege_t prev;
        test_name = "trap_entry";
        mtvec_val = next_random();
        stvec_val = next_random();
        write_csr(MSTATUS, 32'h0);
        write_csr(MTVEC, mtvec_val);
        write_csr(STVEC, stvec_val);
        // Cause 8 delegated, cause 2 stays in machine mode
        write_csr(MEDELEG, 32'h0000_0100);

        prev = privilege;
        pc   = next_random();
        tval = next_random();
        raise_trap(4'd8, tval, pc, target);
        check_word("supervisor target pc", stvec_val & 32'hFFFF_FFFC, target);
        idle_cycle();
        check_word("supervisor privilege", 32'd1, {30'd0, privilege});
        check_word("spp", {31'd0, prev[0]}, {31'd0, mstatus[8]});
        read_csr(SEPC, value);
        check_word("sepc", pc, value);
        read_csr(SCAUSE, value);
        check_word("scause", 32'd8, value);
        read_csr(STVAL, value);
        check_word("stval", tval, value);

        prev = privilege;
        pc   = next_random();
        tval = next_random();
        raise_trap(4'd2, tval, pc, target);
        check_word("machine target pc", mtvec_val & 32'hFFFF_FFFC, target);
        idle_cycle();
        check_word("machine privilege", 32'd3, {30'd0, privilege});
        check_word("mpp", {30'd0, prev}, {30'd0, mstatus[12:11]});
        read_csr(MEPC, value);
        check_word("mepc", pc, value);
        read_csr(MCAUSE, value);
        check_word("mcause", 32'd2, value);
        read_csr(MTVAL, value);
        check_word("mtval", tval, value);
    endtask

    task automatic test_trap_return();
        word_t epc;
        word_t old_status;
        word_t target;
        test_name = "trap_return";
        // sret from machine to supervisor with spp and spie set, sie clear
        epc        = next_random();
        old_status = (next_random() & 32'h000C_0000) | 32'h0000_0120;
        write_csr(SEPC, epc);
        write_csr(MSTATUS, old_status);
        return_from_trap(PRIV_SUPERVISOR, target);
        check_word("sret pc", epc, target);
        idle_cycle();
        check_word("sret privilege", {31'd0, old_status[8]}, {30'd0, privilege});
        check_word("spp cleared", 32'd0, {31'd0, mstatus[8]});
        check_word("sie from spie", {31'd0, old_status[5]}, {31'd0, mstatus[1]});

        // mret from supervisor to machine with mpie set and mie clear
        epc        = next_random();
        old_status = (next_random() & 32'h000C_0000) | 32'h0000_1880;
        write_csr(MEPC, epc);
        write_csr(MSTATUS, old_status);
        return_from_trap(PRIV_MACHINE, target);
        check_word("mret pc", epc, target);
        idle_cycle();
        check_word("mret privilege", {30'd0, old_status[12:11]}, {30'd0, privilege});
        check_word("mpp cleared", 32'd0, {30'd0, mstatus[12:11]});
        check_word("mie from mpie", {31'd0, old_status[7]}, {31'd0, mstatus[3]});
    endtask

    task automatic test_cycle_counter();
        word_t gap;
        word_t first;
        word_t second;
        word_t high;
        test_name = "cycle_counter";
        gap = 32'd5 + next_random() % 32'd20;
        read_csr(CYCLE, first);
        repeat (gap - 1) idle_cycle();
        read_csr(CYCLE, second);
        check_word("cycle delta", gap, second - first);
        read_csr(CYCLEH, high);
        check_word("cycleh", 32'h0, high);
    endtask

`endif

/* verif/csr_tb.sv */
// Directed testbench for the CSR unit.
// Inputs change on the rising edge and outputs are sampled on the
// falling edge. Tests run in a fixed order and share the DUT state.
`timescale 1ns/1ps
`default_nettype none

module csr_tb;
    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 3;
    // Rough cycle budget per test, summed for the watchdog
    localparam int RUN_CYCLES    = RESET_CYCLES + 12 + 24 + 10 + 24 + 20 + 30;
    localparam int MARGIN_CYCLES = 200;

    logic       clk;
    logic       rst;
    csr_addr_t  read_addr;
    logic       write_enable;
    csr_addr_t  write_addr;
    word_t      write_value;
    logic       trap_valid;
    cause_t     trap_cause;
    word_t      trap_tval;
    word_t      trap_pc;
    logic       trap_return;
    privilege_t trap_return_priv;
    word_t      read_value;
    word_t      next_pc;
    privilege_t privilege;
    word_t      mstatus;

    int         error_count;
    int         check_count;
    string      test_name;
    word_t      rand_state;

    csr_unit i_dut (
        .clk              (clk),
        .rst              (rst),
        .read_addr        (read_addr),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_value      (write_value),
        .trap_valid       (trap_valid),
        .trap_cause       (trap_cause),
        .trap_tval        (trap_tval),
        .trap_pc          (trap_pc),
        .trap_return      (trap_return),
        .trap_return_priv (trap_return_priv),
        .read_value       (read_value),
        .next_pc          (next_pc),
        .privilege        (privilege),
        .mstatus          (mstatus)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // LCG with the usual 32-bit multiplier and increment
    function automatic word_t next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // ------------------------------------------------------------------
    // Bus helpers, one clock per operation
    // ------------------------------------------------------------------
    task automatic drive_idle();
        write_enable <= 1'b0;
        trap_valid   <= 1'b0;
        trap_return  <= 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        drive_idle();
        @(negedge clk);
    endtask

    task automatic write_csr(input csr_addr_t addr, input word_t value);
        @(posedge clk);
        drive_idle();
        write_enable <= 1'b1;
        write_addr   <= addr;
        write_value  <= value;
        @(negedge clk);
    endtask

    task automatic read_csr(input csr_addr_t addr, output word_t value);
        @(posedge clk);
        drive_idle();
        read_addr <= addr;
        @(negedge clk);
        value = read_value;
    endtask

    `include "csr_tb_tasks.svh"

    initial begin
        rst              = 1'b1;
        read_addr        = '0;
        write_enable     = 1'b0;
        write_addr       = '0;
        write_value      = '0;
        trap_valid       = 1'b0;
        trap_cause       = '0;
        trap_tval        = '0;
        trap_pc          = '0;
        trap_return      = 1'b0;
        trap_return_priv = PRIV_MACHINE;
        rand_state       = 32'h88b4;
        error_count      = 0;
        check_count      = 0;
        test_name        = "init";

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_after_reset();
        test_write_readback();
        test_sstatus_mask();
        test_trap_entry();
        test_trap_return();
        test_cycle_counter();
        idle_cycle();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog sized from the per-test cycle budget
    initial begin
        #(CLK_PERIOD * (RUN_CYCLES + MARGIN_CYCLES));
        $display("Timeout: tests did not finish within %0d cycles",
                 RUN_CYCLES + MARGIN_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/csr_unit.sv */
// CSR unit top for an RV32 core with machine and supervisor modes.
// Reads are combinational; writes, traps and returns take effect on
// the next clock. No interrupts and no illegal-access reporting.
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  csr_types_pkg::csr_addr_t  read_addr,
    input  logic                      write_enable,
    input  csr_types_pkg::csr_addr_t  write_addr,
    input  csr_types_pkg::word_t      write_value,
    input  logic                      trap_valid,
    input  csr_types_pkg::cause_t     trap_cause,
    input  csr_types_pkg::word_t      trap_tval,
    input  csr_types_pkg::word_t      trap_pc,
    input  logic                      trap_return,
    input  csr_types_pkg::privilege_t trap_return_priv,
    output csr_types_pkg::word_t      read_value,
    output csr_types_pkg::word_t      next_pc,
    output csr_types_pkg::privilege_t privilege,
    output csr_types_pkg::word_t      mstatus
);
    import csr_types_pkg::*;

    // ------------------------------------------------------------------
    // Internal nets
    // ------------------------------------------------------------------
    privilege_t  next_priv;
    status_u     next_status;
    status_u     status;
    logic        capture_m;
    logic        capture_s;
    word_t       medeleg;
    word_t       mtvec;
    word_t       stvec;
    word_t       mscratch;
    word_t       sscratch;
    word_t       mepc;
    word_t       sepc;
    word_t       mtval;
    word_t       stval;
    cause_t      mcause;
    cause_t      scause;
    logic [63:0] cycle;

    assign mstatus = status.raw;

    csr_trap_ctrl i_trap_ctrl (
        .trap_valid       (trap_valid),
        .trap_cause       (trap_cause),
        .trap_return      (trap_return),
        .trap_return_priv (trap_return_priv),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_value      (write_value),
        .cur_priv         (privilege),
        .cur_status       (status),
        .medeleg          (medeleg),
        .mtvec            (mtvec),
        .stvec            (stvec),
        .mepc             (mepc),
        .sepc             (sepc),
        .next_priv        (next_priv),
        .next_status      (next_status),
        .next_pc          (next_pc),
        .capture_m        (capture_m),
        .capture_s        (capture_s)
    );

    csr_regfile i_regfile (
        .clk          (clk),
        .rst          (rst),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_value  (write_value),
        .trap_cause   (trap_cause),
        .trap_tval    (trap_tval),
        .trap_pc      (trap_pc),
        .capture_m    (capture_m),
        .capture_s    (capture_s),
        .next_priv    (next_priv),
        .next_status  (next_status),
        .priv         (privilege),
        .status       (status),
        .medeleg      (medeleg),
        .mtvec        (mtvec),
        .stvec        (stvec),
        .mscratch     (mscratch),
        .sscratch     (sscratch),
        .mepc         (mepc),
        .sepc         (sepc),
        .mtval        (mtval),
        .stval        (stval),
        .mcause       (mcause),
        .scause       (scause),
        .cycle        (cycle)
    );

    csr_read_port i_read_port (
        .read_addr  (read_addr),
        .status     (status),
        .medeleg    (medeleg),
        .mtvec      (mtvec),
        .stvec      (stvec),
        .mscratch   (mscratch),
        .sscratch   (sscratch),
        .mepc       (mepc),
        .sepc       (sepc),
        .mtval      (mtval),
        .stval      (stval),
        .mcause     (mcause),
        .scause     (scause),
        .cycle      (cycle),
        .read_value (read_value)
    );

endmodule

`default_nettype wire

/* logic/csr_read_port.sv */
// Combinational CSR read mux.
// Unmapped addresses read zero and are not reported as illegal.
`timescale 1ns/1ps
`default_nettype none

module csr_read_port (
    input  csr_types_pkg::csr_addr_t read_addr,
    input  csr_types_pkg::status_u   status,
    input  csr_types_pkg::word_t     medeleg,
    input  csr_types_pkg::word_t     mtvec,
    input  csr_types_pkg::word_t     stvec,
    input  csr_types_pkg::word_t     mscratch,
    input  csr_types_pkg::word_t     sscratch,
    input  csr_types_pkg::word_t     mepc,
    input  csr_types_pkg::word_t     sepc,
    input  csr_types_pkg::word_t     mtval,
    input  csr_types_pkg::word_t     stval,
    input  csr_types_pkg::cause_t    mcause,
    input  csr_types_pkg::cause_t    scause,
    input  logic [63:0]              cycle,
    output csr_types_pkg::word_t     read_value
);
    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    always_comb begin
        case (read_addr)
            // Supervisor view
            SSTATUS:   read_value = status.raw & SSTATUS_MASK;
            STVEC:     read_value = stvec;
            SSCRATCH:  read_value = sscratch;
            SEPC:      read_value = sepc;
            SCAUSE:    read_value = word_t'(scause);
            STVAL:     read_value = stval;

            // Machine view
            MSTATUS:   read_value = status.raw;
            MISA:      read_value = MISA_VALUE;
            MEDELEG:   read_value = medeleg;
            MTVEC:     read_value = mtvec;
            MSCRATCH:  read_value = mscratch;
            MEPC:      read_value = mepc;
            MCAUSE:    read_value = word_t'(mcause);
            MTVAL:     read_value = mtval;

            // Counter halves
            CYCLE:     read_value = cycle[31:0];
            CYCLEH:    read_value = cycle[63:32];

            MVENDORID: read_value = VENDOR_ID;
            MARCHID:   read_value = ARCH_ID;
            MIMPID:    read_value = IMPL_ID;
            MHARTID:   read_value = HART_ID;
            default:   read_value = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/csr_regfile.sv */
// Architectural CSR state and the 64-bit cycle counter.
// Status and privilege come in already decided and load every cycle.
// A capture strobe beats a CSR write to the same epc, cause or tval.
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      write_enable,
    input  csr_types_pkg::csr_addr_t  write_addr,
    input  csr_types_pkg::word_t      write_value,
    input  csr_types_pkg::cause_t     trap_cause,
    input  csr_types_pkg::word_t      trap_tval,
    input  csr_types_pkg::word_t      trap_pc,
    input  logic                      capture_m,
    input  logic                      capture_s,
    input  csr_types_pkg::privilege_t next_priv,
    input  csr_types_pkg::status_u    next_status,
    output csr_types_pkg::privilege_t priv,
    output csr_types_pkg::status_u    status,
    output csr_types_pkg::word_t      medeleg,
    output csr_types_pkg::word_t      mtvec,
    output csr_types_pkg::word_t      stvec,
    output csr_types_pkg::word_t      mscratch,
    output csr_types_pkg::word_t      sscratch,
    output csr_types_pkg::word_t      mepc,
    output csr_types_pkg::word_t      sepc,
    output csr_types_pkg::word_t      mtval,
    output csr_types_pkg::word_t      stval,
    output csr_types_pkg::cause_t     mcause,
    output csr_types_pkg::cause_t     scause,
    output logic [63:0]               cycle
);
    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    // ------------------------------------------------------------------
    // Cycle counter, privilege and status
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle  <= '0;
            priv   <= PRIV_MACHINE;
            status <= '0;
        end else begin
            cycle  <= cycle + 64'd1;
            priv   <= next_priv;
            status <= next_status;
        end
    end

    // ------------------------------------------------------------------
    // Software-written registers and trap capture
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            medeleg  <= '0;
            mtvec    <= '0;
            stvec    <= '0;
            mscratch <= '0;
            sscratch <= '0;
            mepc     <= '0;
            sepc     <= '0;
            mtval    <= '0;
            stval    <= '0;
            mcause   <= '0;
            scause   <= '0;
        end else begin
            if (write_enable) begin
                case (write_addr)
                    MEDELEG:  medeleg  <= write_value;
                    MTVEC:    mtvec    <= write_value;
                    STVEC:    stvec    <= write_value;
                    MSCRATCH: mscratch <= write_value;
                    SSCRATCH: sscratch <= write_value;
                    MEPC:     mepc     <= write_value;
                    SEPC:     sepc     <= write_value;
                    MTVAL:    mtval    <= write_value;
                    STVAL:    stval    <= write_value;
                    // Exception code lives in the low bits
                    MCAUSE:   mcause   <= write_value[3:0];
                    SCAUSE:   scause   <= write_value[3:0];
                    default:  ;
                endcase
            end

            // Later assignments override the write above
            if (capture_m) begin
                mepc   <= trap_pc;
                mcause <= trap_cause;
                mtval  <= trap_tval;
            end
            if (capture_s) begin
                sepc   <= trap_pc;
                scause <= trap_cause;
                stval  <= trap_tval;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/csr_trap_ctrl.sv */
// Next-state logic for privilege and status, and the trap target pc.
// Purely combinational. A trap wins over a return, and both win over a
// status write in the same cycle. mie and sie are left alone on entry.
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl (
    input  logic                      trap_valid,
    input  csr_types_pkg::cause_t     trap_cause,
    input  logic                      trap_return,
    input  csr_types_pkg::privilege_t trap_return_priv,
    input  logic                      write_enable,
    input  csr_types_pkg::csr_addr_t  write_addr,
    input  csr_types_pkg::word_t      write_value,
    input  csr_types_pkg::privilege_t cur_priv,
    input  csr_types_pkg::status_u    cur_status,
    input  csr_types_pkg::word_t      medeleg,
    input  csr_types_pkg::word_t      mtvec,
    input  csr_types_pkg::word_t      stvec,
    input  csr_types_pkg::word_t      mepc,
    input  csr_types_pkg::word_t      sepc,
    output csr_types_pkg::privilege_t next_priv,
    output csr_types_pkg::status_u    next_status,
    output csr_types_pkg::word_t      next_pc,
    output logic                      capture_m,
    output logic                      capture_s
);
    import csr_types_pkg::*;
    import csr_addr_pkg::*;

    // Cause is delegated to supervisor when its medeleg bit is set
    logic delegate;

    assign delegate = medeleg[trap_cause];

    always_comb begin
        next_priv   = cur_priv;
        next_status = cur_status;
        next_pc     = '0;
        capture_m   = 1'b0;
        capture_s   = 1'b0;

        if (trap_valid) begin
            if (delegate) begin
                next_priv              = PRIV_SUPERVISOR;
                next_status.fields.spp = cur_priv[0];
                next_pc                = {stvec[31:2], 2'b00};
                capture_s              = 1'b1;
            end else begin
                next_priv              = PRIV_MACHINE;
                next_status.fields.mpp = cur_priv;
                next_pc                = {mtvec[31:2], 2'b00};
                capture_m              = 1'b1;
            end
        end else if (trap_return) begin
            // mret for machine, anything else takes the sret path
            if (trap_return_priv == PRIV_MACHINE) begin
                next_priv               = privilege_t'(cur_status.fields.mpp);
                next_status.fields.mpp  = PRIV_USER;
                next_status.fields.mie  = cur_status.fields.mpie;
                next_pc                 = mepc;
            end else begin
                next_priv               = privilege_t'({1'b0, cur_status.fields.spp});
                next_status.fields.spp  = 1'b0;
                next_status.fields.sie  = cur_status.fields.spie;
                next_pc                 = sepc;
            end
        end else if (write_enable && write_addr == MSTATUS) begin
            next_status.raw = write_value;
        end else if (write_enable && write_addr == SSTATUS) begin
            // Only the supervisor-visible bits change
            next_status.raw = (cur_status.raw & ~SSTATUS_MASK)
                            | (write_value & SSTATUS_MASK);
        end
    end

endmodule

`default_nettype wire

/* logic/csr_addr_pkg.sv */
// CSR address map and the constant identification values.
// Only the addresses that the unit decodes are listed here.
`default_nettype none

package csr_addr_pkg;

    import csr_types_pkg::*;

    // ------------------------------------------------------------------
    // Supervisor trap setup and handling
    // ------------------------------------------------------------------
    localparam csr_addr_t SSTATUS   = 12'h100;
    localparam csr_addr_t STVEC     = 12'h105;
    localparam csr_addr_t SSCRATCH  = 12'h140;
    localparam csr_addr_t SEPC      = 12'h141;
    localparam csr_addr_t SCAUSE    = 12'h142;
    localparam csr_addr_t STVAL     = 12'h143;

    // ------------------------------------------------------------------
    // Machine trap setup and handling
    // ------------------------------------------------------------------
    localparam csr_addr_t MSTATUS   = 12'h300;
    localparam csr_addr_t MISA      = 12'h301;
    localparam csr_addr_t MEDELEG   = 12'h302;
    localparam csr_addr_t MTVEC     = 12'h305;
    localparam csr_addr_t MSCRATCH  = 12'h340;
    localparam csr_addr_t MEPC      = 12'h341;
    localparam csr_addr_t MCAUSE    = 12'h342;
    localparam csr_addr_t MTVAL     = 12'h343;

    // Counters and machine information
    localparam csr_addr_t CYCLE     = 12'hC00;
    localparam csr_addr_t CYCLEH    = 12'hC80;
    localparam csr_addr_t MVENDORID = 12'hF11;
    localparam csr_addr_t MARCHID   = 12'hF12;
    localparam csr_addr_t MIMPID    = 12'hF13;
    localparam csr_addr_t MHARTID   = 12'hF14;

    // MXL = 1 (32 bit), extension I only
    localparam word_t MISA_VALUE = 32'h4000_0100;

    // Non-commercial, no arch or impl number, single hart
    localparam word_t VENDOR_ID  = 32'd0;
    localparam word_t ARCH_ID    = 32'd0;
    localparam word_t IMPL_ID    = 32'd0;
    localparam word_t HART_ID    = 32'd0;

endpackage

`default_nettype wire

/* logic/csr_types_pkg.sv */
// Data formats shared by the CSR unit.
// Only machine and supervisor trap state is modelled, and interrupt
// fields such as mie stay wherever software writes them.
`default_nettype none

package csr_types_pkg;

    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;

    // Exception code only, since there is no interrupt bit
    typedef logic [3:0] cause_t;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } privilege_t;

    // ------------------------------------------------------------------
    // mstatus layout, RV32
    // ------------------------------------------------------------------
    typedef struct packed {
        logic       sd;
        logic [7:0] rsvd_30_23;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] rsvd_10_9;
        logic       spp;
        logic       mpie;
        logic       rsvd_6;
        logic       spie;
        logic       upie;
        logic       mie;
        logic       rsvd_2;
        logic       sie;
        logic       uie;
    } status_fields_t;

    // Raw word for CSR writes, fields for traps and returns
    typedef union packed {
        word_t          raw;
        status_fields_t fields;
    } status_u;

    // sd, mxr, sum, xs, fs, spp, spie, upie, sie and uie
    localparam word_t SSTATUS_MASK = 32'h800D_E133;

endpackage

`default_nettype wire
